/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing
TOP       ?= axi_mux_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the simulation output holds the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* filelist.f */
+incdir+src
src/axi_mux_pkg.sv
src/axi_mux_req_arbiter.sv
src/axi_mux_w_steer.sv
src/axi_mux_resp_router.sv
src/axi_mux_top.sv
sim/axi_mux_tb.sv

/* sim/axi_mux_tb.sv */
`timescale 1ns/1ps
`include "axi_mux_defines.svh"

module axi_mux_tb;
  import axi_mux_pkg::*;

  localparam int NP      = `AXI_MUX_NUM_PORTS;
  localparam int SID_W   = `AXI_MUX_SLV_ID_W;
  localparam int MID_W   = `AXI_MUX_MST_ID_W;
  localparam int ADDR_W  = `AXI_MUX_ADDR_W;
  localparam int DATA_W  = `AXI_MUX_DATA_W;
  localparam int STRB_W  = `AXI_MUX_DATA_W / 8;
  localparam int LEN_W   = `AXI_MUX_LEN_W;
  localparam int TIMEOUT = 50;

  logic clk_i;
  logic rst_i;

  // Manager ports
  logic [NP-1:0]             slv_aw_valid_i, slv_aw_ready_o;
  logic [NP-1:0][SID_W-1:0]  slv_aw_id_i;
  logic [NP-1:0][ADDR_W-1:0] slv_aw_addr_i;
  logic [NP-1:0][LEN_W-1:0]  slv_aw_len_i;
  logic [NP-1:0]             slv_w_valid_i, slv_w_last_i, slv_w_ready_o;
  logic [NP-1:0][DATA_W-1:0] slv_w_data_i;
  logic [NP-1:0][STRB_W-1:0] slv_w_strb_i;
  logic [NP-1:0]             slv_b_valid_o, slv_b_ready_i;
  logic [NP-1:0][SID_W-1:0]  slv_b_id_o;
  logic [NP-1:0][1:0]        slv_b_resp_o;
  logic [NP-1:0]             slv_ar_valid_i, slv_ar_ready_o;
  logic [NP-1:0][SID_W-1:0]  slv_ar_id_i;
  logic [NP-1:0][ADDR_W-1:0] slv_ar_addr_i;
  logic [NP-1:0][LEN_W-1:0]  slv_ar_len_i;
  logic [NP-1:0]             slv_r_valid_o, slv_r_last_o, slv_r_ready_i;
  logic [NP-1:0][SID_W-1:0]  slv_r_id_o;
  logic [NP-1:0][DATA_W-1:0] slv_r_data_o;
  logic [NP-1:0][1:0]        slv_r_resp_o;

  // Merged port
  logic              mst_aw_valid_o, mst_aw_ready_i;
  logic [MID_W-1:0]  mst_aw_id_o;
  logic [ADDR_W-1:0] mst_aw_addr_o;
  logic [LEN_W-1:0]  mst_aw_len_o;
  logic              mst_w_valid_o, mst_w_last_o, mst_w_ready_i;
  logic [DATA_W-1:0] mst_w_data_o;
  logic [STRB_W-1:0] mst_w_strb_o;
  logic              mst_b_valid_i, mst_b_ready_o;
  logic [MID_W-1:0]  mst_b_id_i;
  logic [1:0]        mst_b_resp_i;
  logic              mst_ar_valid_o, mst_ar_ready_i;
  logic [MID_W-1:0]  mst_ar_id_o;
  logic [ADDR_W-1:0] mst_ar_addr_o;
  logic [LEN_W-1:0]  mst_ar_len_o;
  logic              mst_r_valid_i, mst_r_last_i, mst_r_ready_o;
  logic [MID_W-1:0]  mst_r_id_i;
  logic [DATA_W-1:0] mst_r_data_i;
  logic [1:0]        mst_r_resp_i;

  int    errors;
  int    checks;
  int    test_errors;
  int    tests_failed;
  string cur_test;

  axi_mux_top u_dut (.*);

  always #5 clk_i = ~clk_i;

  // --------------------
  // Helpers
  // --------------------
  task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      test_errors++;
      $display("Mismatch in %s (%s): expected 0x%0h, actual 0x%0h", cur_test, what, exp, act);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    test_errors++;
    $display("Error in %s: %s", cur_test, msg);
  endtask

  task automatic idle_inputs();
    slv_aw_valid_i = '0;
    slv_aw_id_i    = '0;
    slv_aw_addr_i  = '0;
    slv_aw_len_i   = '0;
    slv_w_valid_i  = '0;
    slv_w_data_i   = '0;
    slv_w_strb_i   = '0;
    slv_w_last_i   = '0;
    slv_b_ready_i  = '0;
    slv_ar_valid_i = '0;
    slv_ar_id_i    = '0;
    slv_ar_addr_i  = '0;
    slv_ar_len_i   = '0;
    slv_r_ready_i  = '0;
    mst_aw_ready_i = 1'b0;
    mst_w_ready_i  = 1'b0;
    mst_b_valid_i  = 1'b0;
    mst_b_id_i     = '0;
    mst_b_resp_i   = '0;
    mst_ar_ready_i = 1'b0;
    mst_r_valid_i  = 1'b0;
    mst_r_id_i     = '0;
    mst_r_data_i   = '0;
    mst_r_resp_i   = '0;
    mst_r_last_i   = 1'b0;
  endtask

  // Fresh arbiter pointers and an empty W FIFO for every test
  task automatic apply_reset();
    @(negedge clk_i);
    idle_inputs();
    rst_i = 1'b1;
    repeat (5) @(negedge clk_i);
    rst_i = 1'b0;
    #1;
    check("idle merged valids", 0, 32'({mst_aw_valid_o, mst_w_valid_o, mst_ar_valid_o}));
    check("idle port handshakes", 0,
          32'({slv_aw_ready_o, slv_w_ready_o, slv_ar_ready_o, slv_b_valid_o, slv_r_valid_o}));
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = 0;
    apply_reset();
  endtask

  task automatic end_test();
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("%s done, %0d error(s)", cur_test, test_errors);
  endtask

  // Offers one AW and returns at the falling edge after its transfer
  task automatic send_aw(input port_idx_t p, input logic [SID_W-1:0] id,
                         input logic [ADDR_W-1:0] addr, input logic [LEN_W-1:0] len);
    int n;
    @(negedge clk_i);
    slv_aw_valid_i[p] = 1'b1;
    slv_aw_id_i[p]    = id;
    slv_aw_addr_i[p]  = addr;
    slv_aw_len_i[p]   = len;
    #1;
    n = 0;
    while (!slv_aw_ready_o[p] && n < TIMEOUT) begin
      @(negedge clk_i);
      #1;
      n++;
    end
    if (!slv_aw_ready_o[p]) begin
      report_error($sformatf("timed out waiting for AW ready on port %0d", p));
    end
    check("aw id", (32'(p) << SID_W) | 32'(id), 32'(mst_aw_id_o));
    @(negedge clk_i);
    slv_aw_valid_i[p] = 1'b0;
  endtask

  task automatic send_w_beat(input port_idx_t p, input logic [DATA_W-1:0] data,
                             input logic last);
    int n;
    @(negedge clk_i);
    slv_w_valid_i[p] = 1'b1;
    slv_w_data_i[p]  = data;
    slv_w_strb_i[p]  = '1;
    slv_w_last_i[p]  = last;
    #1;
    n = 0;
    while (!slv_w_ready_o[p] && n < TIMEOUT) begin
      @(negedge clk_i);
      #1;
      n++;
    end
    if (!slv_w_ready_o[p]) begin
      report_error($sformatf("timed out waiting for W ready on port %0d", p));
    end
    check("w data", data, mst_w_data_o);
    @(negedge clk_i);
    slv_w_valid_i[p] = 1'b0;
    slv_w_last_i[p]  = 1'b0;
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic test_id_extend();
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
    int                n;
    start_test("test_id_extend");
    addr = ADDR_W'($urandom());
    len  = LEN_W'($urandom());
    @(negedge clk_i);
    mst_aw_ready_i    = 1'b1;
    slv_aw_valid_i[2] = 1'b1;
    slv_aw_id_i[2]    = SID_W'(5);
    slv_aw_addr_i[2]  = addr;
    slv_aw_len_i[2]   = len;
    #1;
    n = 0;
    while (!slv_aw_ready_o[2] && n < TIMEOUT) begin
      @(negedge clk_i);
      #1;
      n++;
    end
    if (!slv_aw_ready_o[2]) begin
      report_error("timed out waiting for AW ready on port 2");
    end
    check("aw valid", 1, 32'(mst_aw_valid_o));
    check("aw id", (2 << SID_W) + 5, 32'(mst_aw_id_o));
    check("aw addr", 32'(addr), 32'(mst_aw_addr_o));
    check("aw len", 32'(len), 32'(mst_aw_len_o));
    @(negedge clk_i);
    slv_aw_valid_i[2] = 1'b0;
    // Same extension on the read address channel
    addr              = ADDR_W'($urandom());
    len               = LEN_W'($urandom());
    mst_ar_ready_i    = 1'b1;
    slv_ar_valid_i[3] = 1'b1;
    slv_ar_id_i[3]    = SID_W'(5);
    slv_ar_addr_i[3]  = addr;
    slv_ar_len_i[3]   = len;
    #1;
    n = 0;
    while (!slv_ar_ready_o[3] && n < TIMEOUT) begin
      @(negedge clk_i);
      #1;
      n++;
    end
    if (!slv_ar_ready_o[3]) begin
      report_error("timed out waiting for AR ready on port 3");
    end
    check("ar id", (3 << SID_W) + 5, 32'(mst_ar_id_o));
    check("ar addr", 32'(addr), 32'(mst_ar_addr_o));
    check("ar len", 32'(len), 32'(mst_ar_len_o));
    @(negedge clk_i);
    slv_ar_valid_i[3] = 1'b0;
    end_test();
  endtask

  task automatic test_round_robin();
    port_idx_t port;
    int        n;
    start_test("test_round_robin");
    @(negedge clk_i);
    mst_ar_ready_i = 1'b1;
    // All ports keep requesting, so only a rotating priority reaches port 3
    slv_ar_valid_i = '1;
    // Port i uses ID 8 + i
    slv_ar_id_i    = {4'hB, 4'hA, 4'h9, 4'h8};
    for (int k = 0; k < NP; k++) begin
      #1;
      n = 0;
      while (!mst_ar_valid_o && n < TIMEOUT) begin
        @(negedge clk_i);
        #1;
        n++;
      end
      if (!mst_ar_valid_o) begin
        report_error("timed out waiting for merged AR valid");
      end
      port = mst_ar_id_o[MID_W-1:SID_W];
      check("granted port", k, 32'(port));
      check("txn id", 32'(k) + 8, 32'(mst_ar_id_o[SID_W-1:0]));
      check("port ready", 32'(1) << k, 32'(slv_ar_ready_o));
      @(negedge clk_i);
    end
    slv_ar_valid_i = '0;
    end_test();
  endtask

  task automatic test_w_order();
    logic [DATA_W-1:0] d1a;
    logic [DATA_W-1:0] d1b;
    logic [DATA_W-1:0] d3;
    int                n;
    start_test("test_w_order");
    d1a = $urandom();
    d1b = $urandom();
    d3  = $urandom();
    @(negedge clk_i);
    mst_aw_ready_i = 1'b1;
    mst_w_ready_i  = 1'b1;
    send_aw(2'd1, SID_W'(1), ADDR_W'(16'h0100), LEN_W'(1));
    send_aw(2'd3, SID_W'(3), ADDR_W'(16'h0300), LEN_W'(0));
    // Port 3 is ready with data but sits behind port 1 in the order
    slv_w_valid_i[3] = 1'b1;
    slv_w_data_i[3]  = d3;
    slv_w_strb_i[3]  = 4'hC;
    slv_w_last_i[3]  = 1'b1;
    repeat (3) begin
      #1;
      check("port 3 ready early", 0, 32'(slv_w_ready_o[3]));
      check("w valid early", 0, 32'(mst_w_valid_o));
      @(negedge clk_i);
    end
    slv_w_valid_i[1] = 1'b1;
    slv_w_data_i[1]  = d1a;
    slv_w_strb_i[1]  = 4'hF;
    slv_w_last_i[1]  = 1'b0;
    #1;
    check("beat 0 data", d1a, mst_w_data_o);
    check("beat 0 strb", 32'hF, 32'(mst_w_strb_o));
    check("beat 0 last", 0, 32'(mst_w_last_o));
    check("port 1 ready", 1, 32'(slv_w_ready_o[1]));
    check("port 3 ready", 0, 32'(slv_w_ready_o[3]));
    @(negedge clk_i);
    slv_w_data_i[1] = d1b;
    slv_w_last_i[1] = 1'b1;
    #1;
    check("beat 1 data", d1b, mst_w_data_o);
    check("beat 1 last", 1, 32'(mst_w_last_o));
    check("port 3 ready", 0, 32'(slv_w_ready_o[3]));
    @(negedge clk_i);
    slv_w_valid_i[1] = 1'b0;
    slv_w_last_i[1]  = 1'b0;
    #1;
    n = 0;
    while (!slv_w_ready_o[3] && n < TIMEOUT) begin
      @(negedge clk_i);
      #1;
      n++;
    end
    if (!slv_w_ready_o[3]) begin
      report_error("timed out waiting for W ready on port 3");
    end
    check("port 3 valid", 1, 32'(mst_w_valid_o));
    check("port 3 data", d3, mst_w_data_o);
    check("port 3 strb", 32'hC, 32'(mst_w_strb_o));
    check("port 3 last", 1, 32'(mst_w_last_o));
    @(negedge clk_i);
    slv_w_valid_i[3] = 1'b0;
    slv_w_last_i[3]  = 1'b0;
    end_test();
  endtask

  task automatic test_resp_route();
    logic [DATA_W-1:0] rdata;
    int                n;
    start_test("test_resp_route");
    rdata = $urandom();
    @(negedge clk_i);
    mst_b_valid_i = 1'b1;
    mst_b_id_i    = MID_W'((3 << SID_W) + 7);
    mst_b_resp_i  = 2'b10;
    // Every port ready except the one named in the ID
    slv_b_ready_i = 4'b0111;
    #1;
    check("b valid", 32'h8, 32'(slv_b_valid_o));
    check("b id", 7, 32'(slv_b_id_o[3]));
    check("b resp", 2, 32'(slv_b_resp_o[3]));
    check("b ready held", 0, 32'(mst_b_ready_o));
    @(negedge clk_i);
    slv_b_ready_i = 4'b1000;
    #1;
    n = 0;
    while (!mst_b_ready_o && n < TIMEOUT) begin
      @(negedge clk_i);
      #1;
      n++;
    end
    if (!mst_b_ready_o) begin
      report_error("timed out waiting for merged B ready");
    end
    @(negedge clk_i);
    mst_b_valid_i = 1'b0;
    slv_b_ready_i = '0;
    mst_r_valid_i = 1'b1;
    mst_r_id_i    = MID_W'((1 << SID_W) + 2);
    mst_r_data_i  = rdata;
    mst_r_resp_i  = 2'b01;
    mst_r_last_i  = 1'b1;
    slv_r_ready_i = 4'b1101;
    #1;
    check("r valid", 32'h2, 32'(slv_r_valid_o));
    check("r id", 2, 32'(slv_r_id_o[1]));
    check("r data", rdata, slv_r_data_o[1]);
    check("r resp", 1, 32'(slv_r_resp_o[1]));
    check("r last", 1, 32'(slv_r_last_o[1]));
    check("r ready held", 0, 32'(mst_r_ready_o));
    @(negedge clk_i);
    slv_r_ready_i = 4'b0010;
    #1;
    n = 0;
    while (!mst_r_ready_o && n < TIMEOUT) begin
      @(negedge clk_i);
      #1;
      n++;
    end
    if (!mst_r_ready_o) begin
      report_error("timed out waiting for merged R ready");
    end
    @(negedge clk_i);
    mst_r_valid_i = 1'b0;
    slv_r_ready_i = '0;
    end_test();
  endtask

  task automatic test_aw_backpressure();
    logic [ADDR_W-1:0] addr;
    int                n;
    int                xfers;
    start_test("test_aw_backpressure");
    addr  = ADDR_W'($urandom());
    xfers = 0;
    @(negedge clk_i);
    slv_aw_valid_i[0] = 1'b1;
    slv_aw_id_i[0]    = SID_W'(9);
    slv_aw_addr_i[0]  = addr;
    slv_aw_len_i[0]   = '0;
    repeat (4) begin
      #1;
      check("held valid", 1, 32'(mst_aw_valid_o));
      check("held id", 9, 32'(mst_aw_id_o));
      check("held addr", 32'(addr), 32'(mst_aw_addr_o));
      @(negedge clk_i);
    end
    mst_aw_ready_i = 1'b1;
    #1;
    n = 0;
    while (!slv_aw_ready_o[0] && n < TIMEOUT) begin
      @(negedge clk_i);
      #1;
      n++;
    end
    if (!slv_aw_ready_o[0]) begin
      report_error("timed out waiting for AW ready on port 0");
    end
    if (mst_aw_valid_o && mst_aw_ready_i) begin
      xfers++;
    end
    @(negedge clk_i);
    slv_aw_valid_i[0] = 1'b0;
    repeat (3) begin
      #1;
      if (mst_aw_valid_o && mst_aw_ready_i) begin
        xfers++;
      end
      @(negedge clk_i);
    end
    check("aw transfers", 1, xfers);
    // Drain the first burst, then fill the W order FIFO
    mst_w_ready_i = 1'b1;
    send_w_beat(2'd0, $urandom(), 1'b1);
    for (int k = 0; k < `AXI_MUX_MAX_W_TRANS; k++) begin
      send_aw(2'd1, SID_W'(k), ADDR_W'(k * 16), LEN_W'(0));
    end
    slv_aw_valid_i[2] = 1'b1;
    slv_aw_id_i[2]    = SID_W'(6);
    slv_aw_addr_i[2]  = ADDR_W'(16'h2000);
    slv_aw_len_i[2]   = '0;
    repeat (3) begin
      #1;
      check("fifth aw held back", 0, 32'(mst_aw_valid_o));
      check("port 2 ready early", 0, 32'(slv_aw_ready_o[2]));
      @(negedge clk_i);
    end
    send_w_beat(2'd1, $urandom(), 1'b1);
    #1;
    n = 0;
    while (!mst_aw_valid_o && n < TIMEOUT) begin
      @(negedge clk_i);
      #1;
      n++;
    end
    if (!mst_aw_valid_o) begin
      report_error("timed out waiting for the fifth AW after a W burst");
    end
    check("fifth aw id", (2 << SID_W) + 6, 32'(mst_aw_id_o));
    check("port 2 ready", 1, 32'(slv_aw_ready_o[2]));
    @(negedge clk_i);
    slv_aw_valid_i[2] = 1'b0;
    end_test();
  endtask

  initial begin
    errors       = 0;
    checks       = 0;
    test_errors  = 0;
    tests_failed = 0;
    cur_test     = "init";
    clk_i        = 1'b0;
    rst_i        = 1'b1;
    idle_inputs();
    void'($urandom(32'h51f0));
    test_id_extend();
    test_round_robin();
    test_w_order();
    test_resp_route();
    test_aw_backpressure();
    $display("Tests run: 5, failed: %0d, checks: %0d, errors: %0d",
             tests_failed, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* src/axi_mux_defines.svh */
`ifndef AXI_MUX_DEFINES_SVH
`define AXI_MUX_DEFINES_SVH

// Number of manager ports merged onto the single port
`define AXI_MUX_NUM_PORTS 4
`define AXI_MUX_IDX_W 2

// ID widths, merged side carries the port index on top
`define AXI_MUX_SLV_ID_W 4
`define AXI_MUX_MST_ID_W (`AXI_MUX_IDX_W + `AXI_MUX_SLV_ID_W)

// Address and data channel widths
`define AXI_MUX_ADDR_W 16
`define AXI_MUX_DATA_W 32
`define AXI_MUX_LEN_W 8

// Outstanding AW decisions waiting for their W bursts
`define AXI_MUX_MAX_W_TRANS 4

`endif

/* src/axi_mux_pkg.sv */
`include "axi_mux_defines.svh"

package axi_mux_pkg;

  // Manager port number
  typedef logic [`AXI_MUX_IDX_W-1:0] port_idx_t;

  // ID as seen on a manager port
  typedef logic [`AXI_MUX_SLV_ID_W-1:0] slv_id_t;

  // Split view of the merged-side ID, port index in the upper bits
  typedef struct packed {
    port_idx_t port;
    slv_id_t   txn_id;
  } mst_id_split_t;

  // Merged-side ID, read either as one word or as port plus original ID
  typedef union packed {
    logic [`AXI_MUX_MST_ID_W-1:0] raw;
    mst_id_split_t                split;
  } mst_id_u;

endpackage

/* src/axi_mux_req_arbiter.sv */
`timescale 1ns/1ps
`include "axi_mux_defines.svh"

module axi_mux_req_arbiter (
  input  logic                                             clk_i,
  input  logic                                             rst_i,
  input  logic [`AXI_MUX_NUM_PORTS-1:0]                    req_valid_i,
  input  axi_mux_pkg::slv_id_t [`AXI_MUX_NUM_PORTS-1:0]    req_id_i,
  input  logic [`AXI_MUX_NUM_PORTS-1:0][`AXI_MUX_ADDR_W-1:0] req_addr_i,
  input  logic [`AXI_MUX_NUM_PORTS-1:0][`AXI_MUX_LEN_W-1:0]  req_len_i,
  output logic [`AXI_MUX_NUM_PORTS-1:0]                    req_ready_o,
  output logic                                             gnt_valid_o,
  output logic [`AXI_MUX_MST_ID_W-1:0]                     gnt_id_o,
  output logic [`AXI_MUX_ADDR_W-1:0]                       gnt_addr_o,
  output logic [`AXI_MUX_LEN_W-1:0]                        gnt_len_o,
  output axi_mux_pkg::port_idx_t                           gnt_idx_o,
  input  logic                                             gnt_ready_i
);
  import axi_mux_pkg::*;

  port_idx_t prio_q;
  logic      lock_q;
  port_idx_t lock_idx_q;
  port_idx_t rr_idx;
  logic      rr_found;
  port_idx_t sel_idx;
  mst_id_u   gnt_id;
  logic      xfer;

  // --------------------
  // Round-robin search
  // --------------------
  // First valid port at or after the priority pointer
  always_comb begin
    rr_idx   = prio_q;
    rr_found = 1'b0;
    for (int k = 0; k < `AXI_MUX_NUM_PORTS; k++) begin
      if (!rr_found && req_valid_i[port_idx_t'(prio_q + port_idx_t'(k))]) begin
        rr_idx   = port_idx_t'(prio_q + port_idx_t'(k));
        rr_found = 1'b1;
      end
    end
  end

  // A request already on the merged side keeps the grant
  assign sel_idx     = lock_q ? lock_idx_q : rr_idx;
  assign gnt_valid_o = req_valid_i[sel_idx];
  assign xfer        = gnt_valid_o & gnt_ready_i;

  always_comb begin
    req_ready_o          = '0;
    req_ready_o[sel_idx] = xfer;
  end

  // ID extension with the winning port index
  always_comb begin
    gnt_id.split.port   = sel_idx;
    gnt_id.split.txn_id = req_id_i[sel_idx];
  end

  assign gnt_id_o   = gnt_id.raw;
  assign gnt_addr_o = req_addr_i[sel_idx];
  assign gnt_len_o  = req_len_i[sel_idx];
  assign gnt_idx_o  = sel_idx;

  // --------------------
  // Priority and lock
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      prio_q     <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (xfer) begin
      prio_q <= port_idx_t'(sel_idx + 1'b1);
      lock_q <= 1'b0;
    end else if (gnt_valid_o) begin
      lock_q     <= 1'b1;
      lock_idx_q <= sel_idx;
    end
  end

endmodule

/* src/axi_mux_resp_router.sv */
`timescale 1ns/1ps
`include "axi_mux_defines.svh"

module axi_mux_resp_router #(
  parameter int PAYLOAD_W = 2
) (
  input  logic                          mst_valid_i,
  input  logic [`AXI_MUX_MST_ID_W-1:0]  mst_id_i,
  input  logic [PAYLOAD_W-1:0]          mst_payload_i,
  output logic                          mst_ready_o,
  output logic [`AXI_MUX_NUM_PORTS-1:0] slv_valid_o,
  output axi_mux_pkg::slv_id_t          slv_id_o,
  output logic [PAYLOAD_W-1:0]          slv_payload_o,
  input  logic [`AXI_MUX_NUM_PORTS-1:0] slv_ready_i
);
  import axi_mux_pkg::*;

  mst_id_u resp_id;

  // Upper ID bits name the port that issued the request
  assign resp_id.raw = mst_id_i;

  always_comb begin
    slv_valid_o = '0;
    slv_valid_o[resp_id.split.port] = mst_valid_i;
  end

  assign mst_ready_o   = slv_ready_i[resp_id.split.port];
  assign slv_id_o      = resp_id.split.txn_id;
  // Same payload at every port, only valid selects
  assign slv_payload_o = mst_payload_i;

endmodule

/* src/axi_mux_top.sv */
`timescale 1ns/1ps
`include "axi_mux_defines.svh"

module axi_mux_top (
  input  logic                                                 clk_i,
  input  logic                                                 rst_i,
  // Manager ports
  input  logic [`AXI_MUX_NUM_PORTS-1:0]                        slv_aw_valid_i,
  input  axi_mux_pkg::slv_id_t [`AXI_MUX_NUM_PORTS-1:0]        slv_aw_id_i,
  input  logic [`AXI_MUX_NUM_PORTS-1:0][`AXI_MUX_ADDR_W-1:0]   slv_aw_addr_i,
  input  logic [`AXI_MUX_NUM_PORTS-1:0][`AXI_MUX_LEN_W-1:0]    slv_aw_len_i,
  output logic [`AXI_MUX_NUM_PORTS-1:0]                        slv_aw_ready_o,
  input  logic [`AXI_MUX_NUM_PORTS-1:0]                        slv_w_valid_i,
  input  logic [`AXI_MUX_NUM_PORTS-1:0][`AXI_MUX_DATA_W-1:0]   slv_w_data_i,
  input  logic [`AXI_MUX_NUM_PORTS-1:0][`AXI_MUX_DATA_W/8-1:0] slv_w_strb_i,
  input  logic [`AXI_MUX_NUM_PORTS-1:0]                        slv_w_last_i,
  output logic [`AXI_MUX_NUM_PORTS-1:0]                        slv_w_ready_o,
  output logic [`AXI_MUX_NUM_PORTS-1:0]                        slv_b_valid_o,
  output axi_mux_pkg::slv_id_t [`AXI_MUX_NUM_PORTS-1:0]        slv_b_id_o,
  output logic [`AXI_MUX_NUM_PORTS-1:0][1:0]                   slv_b_resp_o,
  input  logic [`AXI_MUX_NUM_PORTS-1:0]                        slv_b_ready_i,
  input  logic [`AXI_MUX_NUM_PORTS-1:0]                        slv_ar_valid_i,
  input  axi_mux_pkg::slv_id_t [`AXI_MUX_NUM_PORTS-1:0]        slv_ar_id_i,
  input  logic [`AXI_MUX_NUM_PORTS-1:0][`AXI_MUX_ADDR_W-1:0]   slv_ar_addr_i,
  input  logic [`AXI_MUX_NUM_PORTS-1:0][`AXI_MUX_LEN_W-1:0]    slv_ar_len_i,
  output logic [`AXI_MUX_NUM_PORTS-1:0]                        slv_ar_ready_o,
  output logic [`AXI_MUX_NUM_PORTS-1:0]                        slv_r_valid_o,
  output axi_mux_pkg::slv_id_t [`AXI_MUX_NUM_PORTS-1:0]        slv_r_id_o,
  output logic [`AXI_MUX_NUM_PORTS-1:0][`AXI_MUX_DATA_W-1:0]   slv_r_data_o,
  output logic [`AXI_MUX_NUM_PORTS-1:0][1:0]                   slv_r_resp_o,
  output logic [`AXI_MUX_NUM_PORTS-1:0]                        slv_r_last_o,
  input  logic [`AXI_MUX_NUM_PORTS-1:0]                        slv_r_ready_i,
  // Merged port toward the subordinate
  output logic                                                 mst_aw_valid_o,
  output logic [`AXI_MUX_MST_ID_W-1:0]                         mst_aw_id_o,
  output logic [`AXI_MUX_ADDR_W-1:0]                           mst_aw_addr_o,
  output logic [`AXI_MUX_LEN_W-1:0]                            mst_aw_len_o,
  input  logic                                                 mst_aw_ready_i,
  output logic                                                 mst_w_valid_o,
  output logic [`AXI_MUX_DATA_W-1:0]                           mst_w_data_o,
  output logic [`AXI_MUX_DATA_W/8-1:0]                         mst_w_strb_o,
  output logic                                                 mst_w_last_o,
  input  logic                                                 mst_w_ready_i,
  input  logic                                                 mst_b_valid_i,
  input  logic [`AXI_MUX_MST_ID_W-1:0]                         mst_b_id_i,
  input  logic [1:0]                                           mst_b_resp_i,
  output logic                                                 mst_b_ready_o,
  output logic                                                 mst_ar_valid_o,
  output logic [`AXI_MUX_MST_ID_W-1:0]                         mst_ar_id_o,
  output logic [`AXI_MUX_ADDR_W-1:0]                           mst_ar_addr_o,
  output logic [`AXI_MUX_LEN_W-1:0]                            mst_ar_len_o,
  input  logic                                                 mst_ar_ready_i,
  input  logic                                                 mst_r_valid_i,
  input  logic [`AXI_MUX_MST_ID_W-1:0]                         mst_r_id_i,
  input  logic [`AXI_MUX_DATA_W-1:0]                           mst_r_data_i,
  input  logic [1:0]                                           mst_r_resp_i,
  input  logic                                                 mst_r_last_i,
  output logic                                                 mst_r_ready_o
);
  import axi_mux_pkg::*;

  localparam int R_PAYLOAD_W = `AXI_MUX_DATA_W + 3;

  logic                   aw_valid;
  logic                   aw_ready;
  port_idx_t              aw_idx;
  slv_id_t                b_id;
  logic [1:0]             b_resp;
  slv_id_t                r_id;
  logic [R_PAYLOAD_W-1:0] r_payload;

  // --------------------
  // Write path
  // --------------------
  axi_mux_req_arbiter u_aw_arb (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (slv_aw_valid_i),
    .req_id_i    (slv_aw_id_i),
    .req_addr_i  (slv_aw_addr_i),
    .req_len_i   (slv_aw_len_i),
    .req_ready_o (slv_aw_ready_o),
    .gnt_valid_o (aw_valid),
    .gnt_id_o    (mst_aw_id_o),
    .gnt_addr_o  (mst_aw_addr_o),
    .gnt_len_o   (mst_aw_len_o),
    .gnt_idx_o   (aw_idx),
    .gnt_ready_i (aw_ready)
  );

  axi_mux_w_steer u_w_steer (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .aw_valid_i     (aw_valid),
    .aw_idx_i       (aw_idx),
    .aw_ready_o     (aw_ready),
    .mst_aw_valid_o (mst_aw_valid_o),
    .mst_aw_ready_i (mst_aw_ready_i),
    .slv_w_valid_i  (slv_w_valid_i),
    .slv_w_data_i   (slv_w_data_i),
    .slv_w_strb_i   (slv_w_strb_i),
    .slv_w_last_i   (slv_w_last_i),
    .slv_w_ready_o  (slv_w_ready_o),
    .mst_w_valid_o  (mst_w_valid_o),
    .mst_w_data_o   (mst_w_data_o),
    .mst_w_strb_o   (mst_w_strb_o),
    .mst_w_last_o   (mst_w_last_o),
    .mst_w_ready_i  (mst_w_ready_i)
  );

  axi_mux_resp_router #(
    .PAYLOAD_W (2)
  ) u_b_router (
    .mst_valid_i   (mst_b_valid_i),
    .mst_id_i      (mst_b_id_i),
    .mst_payload_i (mst_b_resp_i),
    .mst_ready_o   (mst_b_ready_o),
    .slv_valid_o   (slv_b_valid_o),
    .slv_id_o      (b_id),
    .slv_payload_o (b_resp),
    .slv_ready_i   (slv_b_ready_i)
  );

  // --------------------
  // Read path
  // --------------------
  axi_mux_req_arbiter u_ar_arb (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (slv_ar_valid_i),
    .req_id_i    (slv_ar_id_i),
    .req_addr_i  (slv_ar_addr_i),
    .req_len_i   (slv_ar_len_i),
    .req_ready_o (slv_ar_ready_o),
    .gnt_valid_o (mst_ar_valid_o),
    .gnt_id_o    (mst_ar_id_o),
    .gnt_addr_o  (mst_ar_addr_o),
    .gnt_len_o   (mst_ar_len_o),
    .gnt_idx_o   (),
    .gnt_ready_i (mst_ar_ready_i)
  );

  // R payload packed as data, resp, last
  axi_mux_resp_router #(
    .PAYLOAD_W (R_PAYLOAD_W)
  ) u_r_router (
    .mst_valid_i   (mst_r_valid_i),
    .mst_id_i      (mst_r_id_i),
    .mst_payload_i ({mst_r_data_i, mst_r_resp_i, mst_r_last_i}),
    .mst_ready_o   (mst_r_ready_o),
    .slv_valid_o   (slv_r_valid_o),
    .slv_id_o      (r_id),
    .slv_payload_o (r_payload),
    .slv_ready_i   (slv_r_ready_i)
  );

  // Broadcast of restored IDs and payloads to every port
  for (genvar i = 0; i < `AXI_MUX_NUM_PORTS; i++) begin : gen_resp_fanout
    assign slv_b_id_o[i]   = b_id;
    assign slv_b_resp_o[i] = b_resp;
    assign slv_r_id_o[i]   = r_id;
    assign slv_r_data_o[i] = r_payload[R_PAYLOAD_W-1:3];
    assign slv_r_resp_o[i] = r_payload[2:1];
    assign slv_r_last_o[i] = r_payload[0];
  end

endmodule

/* src/axi_mux_w_steer.sv */
`timescale 1ns/1ps
`include "axi_mux_defines.svh"

module axi_mux_w_steer (
  input  logic                                                 clk_i,
  input  logic                                                 rst_i,
  input  logic                                                 aw_valid_i,
  input  axi_mux_pkg::port_idx_t                               aw_idx_i,
  output logic                                                 aw_ready_o,
  output logic                                                 mst_aw_valid_o,
  input  logic                                                 mst_aw_ready_i,
  input  logic [`AXI_MUX_NUM_PORTS-1:0]                        slv_w_valid_i,
  input  logic [`AXI_MUX_NUM_PORTS-1:0][`AXI_MUX_DATA_W-1:0]   slv_w_data_i,
  input  logic [`AXI_MUX_NUM_PORTS-1:0][`AXI_MUX_DATA_W/8-1:0] slv_w_strb_i,
  input  logic [`AXI_MUX_NUM_PORTS-1:0]                        slv_w_last_i,
  output logic [`AXI_MUX_NUM_PORTS-1:0]                        slv_w_ready_o,
  output logic                                                 mst_w_valid_o,
  output logic [`AXI_MUX_DATA_W-1:0]                           mst_w_data_o,
  output logic [`AXI_MUX_DATA_W/8-1:0]                         mst_w_strb_o,
  output logic                                                 mst_w_last_o,
  input  logic                                                 mst_w_ready_i
);
  import axi_mux_pkg::*;

  localparam int PTR_W = $clog2(`AXI_MUX_MAX_W_TRANS);
  localparam int CNT_W = PTR_W + 1;

  logic             lock_d;
  logic             lock_q;
  logic             fifo_push;
  logic             fifo_pop;
  logic             fifo_full;
  logic             fifo_empty;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  port_idx_t        fifo_mem [`AXI_MUX_MAX_W_TRANS];
  port_idx_t        head_idx;

  assign fifo_full  = (count_q == CNT_W'(`AXI_MUX_MAX_W_TRANS));
  assign fifo_empty = (count_q == '0);
  assign head_idx   = fifo_mem[rd_ptr_q];

  // --------------------
  // AW control
  // --------------------
  // The decision is pushed once, the lock keeps AW valid until accepted
  always_comb begin
    lock_d         = lock_q;
    fifo_push      = 1'b0;
    mst_aw_valid_o = 1'b0;
    aw_ready_o     = 1'b0;
    if (lock_q) begin
      mst_aw_valid_o = 1'b1;
      if (mst_aw_ready_i) begin
        aw_ready_o = 1'b1;
        lock_d     = 1'b0;
      end
    end else if (aw_valid_i && !fifo_full) begin
      mst_aw_valid_o = 1'b1;
      fifo_push      = 1'b1;
      if (mst_aw_ready_i) begin
        aw_ready_o = 1'b1;
      end else begin
        lock_d = 1'b1;
      end
    end
  end

  // --------------------
  // W beat steering
  // --------------------
  assign mst_w_data_o = slv_w_data_i[head_idx];
  assign mst_w_strb_o = slv_w_strb_i[head_idx];
  assign mst_w_last_o = slv_w_last_i[head_idx];

  always_comb begin
    mst_w_valid_o = 1'b0;
    slv_w_ready_o = '0;
    fifo_pop      = 1'b0;
    if (!fifo_empty) begin
      mst_w_valid_o           = slv_w_valid_i[head_idx];
      slv_w_ready_o[head_idx] = mst_w_ready_i;
      // Burst done, move on to the next port in order
      fifo_pop = slv_w_valid_i[head_idx] & mst_w_ready_i & slv_w_last_i[head_idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lock_q   <= 1'b0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      lock_q <= lock_d;
      if (fifo_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (fifo_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(fifo_push) - CNT_W'(fifo_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (fifo_push) begin
      fifo_mem[wr_ptr_q] <= aw_idx_i;
    end
  end

endmodule
